//--- hdl/rv_decode_pkg.sv
/*
 * RV32I decode stage shared definitions
 * Widths, major opcodes, funct codes, immediate formats, the reset PC,
 * the instruction word views and the structs passed to execute.
 */
`default_nettype none

package rv_decode_pkg;

    // ------------------------------
    // Widths and reset state
    // ------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INSTR_W    = 32;

    localparam logic [XLEN-1:0] PC_RESET_ADDR = 32'h1000_0000;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    // ALU funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // SRL or SRA by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Load/store size, funct3[1:0], and the unsigned flag in funct3
    localparam logic [1:0] LS_SIZE_BYTE    = 2'b00;
    localparam logic [1:0] LS_SIZE_HALF    = 2'b01;
    localparam logic [1:0] LS_SIZE_WORD    = 2'b10;
    localparam int         LS_UNSIGNED_BIT = 2;

    // ------------------------------
    // Immediate format select
    // ------------------------------
    localparam int IMM_SEL_W = 3;

    localparam logic [IMM_SEL_W-1:0] IMM_SEL_NONE  = 3'd0;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_I     = 3'd1;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_S     = 3'd2;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_B     = 3'd3;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_U     = 3'd4;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_J     = 3'd5;
    localparam logic [IMM_SEL_W-1:0] IMM_SEL_SHAMT = 3'd6;

    // Instruction word, register and immediate layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r_view;
        struct packed {
            logic [11:0]           imm12;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i_view;
    } instr_u;

    // Micro-op handed to execute
    typedef struct packed {
        logic alu_add, alu_sub, alu_and, alu_or, alu_xor;
        logic alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu;
        logic lsu_load, lsu_store, lsu_byte, lsu_half, lsu_word, lsu_sext;
        logic cfu_beq, cfu_bne, cfu_blt, cfu_bge, cfu_bltu, cfu_bgeu;
        logic cfu_jal, cfu_jalr;
        logic wb_alu, wb_lsu, wb_npc;
        logic [REG_ADDR_W-1:0] rd;
    } uop_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] alu_lhs;
        logic [XLEN-1:0] alu_rhs;
    } operand_t;

endpackage

`default_nettype wire

//--- hdl/pc_tracker.sv
/*
 * Program counter tracking
 * Holds the PC, applies redirects and consumed instructions,
 * and signals fetch when the current word is taken.
 */
`default_nettype none

module pc_tracker (
    input  wire                              g_clk,
    input  wire                              g_resetn,
    input  wire                              instr_valid_i,  // Fetch has a word
    input  wire                              s2_ready_i,     // Execute can accept
    input  wire                              cf_valid_i,     // Redirect request
    input  wire                              cf_ack_i,       // Redirect accepted
    input  wire [rv_decode_pkg::XLEN-1:0]    cf_target_i,
    output logic                             eat_o,          // Consume pulse to fetch
    output logic [rv_decode_pkg::XLEN-1:0]   pc_o,
    output logic [rv_decode_pkg::XLEN-1:0]   npc_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic            redirect;

    assign eat_o    = instr_valid_i && s2_ready_i;
    assign redirect = cf_valid_i && cf_ack_i;

    assign pc_o  = pc_q;
    assign npc_o = pc_q + XLEN'(4);  // 32-bit instructions only

    // A redirect wins over a consumed instruction on the same cycle
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= PC_RESET_ADDR;
        end else if (redirect) begin
            pc_q <= cf_target_i;
        end else if (eat_o) begin
            pc_q <= npc_o;
        end
    end

endmodule

`default_nettype wire

//--- hdl/instr_decode.sv
/*
 * RV32I instruction decoder
 * Turns the opcode and funct fields into register addresses, the
 * micro-op, the immediate format and the trap flag.
 */
`default_nettype none

module instr_decode (
    input  wire rv_decode_pkg::instr_u                  instr_i,
    input  wire                                         ferr_i,      // Fetch bus error
    output logic [rv_decode_pkg::REG_ADDR_W-1:0]        rs1_addr_o,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0]        rs2_addr_o,
    output rv_decode_pkg::uop_t                         uop_o,
    output logic [rv_decode_pkg::IMM_SEL_W-1:0]         imm_sel_o,
    output logic                                        alu_rhs_imm_o,
    output logic                                        trap_o
);

    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_op;     // funct7 bit 5, SUB and SRA
    logic       is_op_reg;
    logic       known_op;
    logic       uses_rs1;
    logic       uses_rs2;

    assign opcode    = instr_i.i_view.opcode;
    assign funct3    = instr_i.i_view.funct3;
    assign alt_op    = instr_i.r_view.funct7[5];
    assign is_op_reg = (opcode == OPC_OP);

    // ------------------------------
    // Register addresses and trap
    // ------------------------------
    assign rs1_addr_o = uses_rs1 ? instr_i.i_view.rs1 : '0;  // x0 gives LUI a zero LHS
    assign rs2_addr_o = uses_rs2 ? instr_i.r_view.rs2 : '0;

    assign trap_o = ferr_i || !known_op;

    // ------------------------------
    // Micro-op decode
    // ------------------------------
    always_comb begin
        uop_o         = '0;
        uop_o.rd      = instr_i.i_view.rd;
        imm_sel_o     = IMM_SEL_NONE;
        alu_rhs_imm_o = 1'b0;
        known_op      = 1'b1;
        uses_rs1      = 1'b1;
        uses_rs2      = 1'b0;

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                uop_o.wb_alu  = 1'b1;
                uses_rs2      = is_op_reg;
                alu_rhs_imm_o = !is_op_reg;
                imm_sel_o     = is_op_reg ? IMM_SEL_NONE : IMM_SEL_I;
                case (funct3)
                    F3_ADD_SUB: begin
                        uop_o.alu_sub = alt_op && is_op_reg;  // No SUBI
                        uop_o.alu_add = !(alt_op && is_op_reg);
                    end
                    F3_SLL: begin
                        uop_o.alu_sll = 1'b1;
                        if (!is_op_reg) begin
                            imm_sel_o = IMM_SEL_SHAMT;
                        end
                    end
                    F3_SLT:  uop_o.alu_slt  = 1'b1;
                    F3_SLTU: uop_o.alu_sltu = 1'b1;
                    F3_XOR:  uop_o.alu_xor  = 1'b1;
                    F3_SR: begin
                        uop_o.alu_sra = alt_op;
                        uop_o.alu_srl = !alt_op;
                        if (!is_op_reg) begin
                            imm_sel_o = IMM_SEL_SHAMT;
                        end
                    end
                    F3_OR:   uop_o.alu_or   = 1'b1;
                    F3_AND:  uop_o.alu_and  = 1'b1;
                endcase
            end
            OPC_LUI: begin
                uses_rs1      = 1'b0;
                uop_o.alu_or  = 1'b1;                // Zero OR immediate
                uop_o.wb_alu  = 1'b1;
                imm_sel_o     = IMM_SEL_U;
                alu_rhs_imm_o = 1'b1;
            end
            OPC_AUIPC: begin
                uses_rs1      = 1'b0;
                uop_o.alu_add = 1'b1;                // Execute supplies the PC
                uop_o.wb_alu  = 1'b1;
                imm_sel_o     = IMM_SEL_U;
                alu_rhs_imm_o = 1'b1;
            end
            OPC_JAL: begin
                uses_rs1      = 1'b0;
                uop_o.cfu_jal = 1'b1;
                uop_o.wb_npc  = 1'b1;                // Link value
                imm_sel_o     = IMM_SEL_J;
            end
            OPC_JALR: begin
                uop_o.cfu_jalr = 1'b1;
                uop_o.wb_npc   = 1'b1;
                imm_sel_o      = IMM_SEL_I;
            end
            OPC_BRANCH: begin
                uses_rs2       = 1'b1;
                uop_o.rd       = '0;
                uop_o.alu_sub  = 1'b1;               // Compare through the ALU
                uop_o.cfu_beq  = (funct3 == F3_BEQ);
                uop_o.cfu_bne  = (funct3 == F3_BNE);
                uop_o.cfu_blt  = (funct3 == F3_BLT);
                uop_o.cfu_bge  = (funct3 == F3_BGE);
                uop_o.cfu_bltu = (funct3 == F3_BLTU);
                uop_o.cfu_bgeu = (funct3 == F3_BGEU);
                imm_sel_o      = IMM_SEL_B;
            end
            OPC_LOAD: begin
                uop_o.lsu_load = 1'b1;
                uop_o.lsu_sext = !funct3[LS_UNSIGNED_BIT];
                uop_o.wb_lsu   = 1'b1;
                imm_sel_o      = IMM_SEL_I;
            end
            OPC_STORE: begin
                uses_rs2        = 1'b1;
                uop_o.rd        = '0;
                uop_o.lsu_store = 1'b1;
                imm_sel_o       = IMM_SEL_S;
            end
            default: begin
                known_op = 1'b0;
                uses_rs1 = 1'b0;
                uop_o.rd = '0;
            end
        endcase

        // Access width shared by loads and stores
        if (uop_o.lsu_load || uop_o.lsu_store) begin
            uop_o.lsu_byte = (funct3[1:0] == LS_SIZE_BYTE);
            uop_o.lsu_half = (funct3[1:0] == LS_SIZE_HALF);
            uop_o.lsu_word = (funct3[1:0] == LS_SIZE_WORD);
        end
    end

endmodule

`default_nettype wire

//--- hdl/operand_gather.sv
/*
 * Operand gather
 * Builds the selected immediate and the ALU operands
 * from the register data returned by the register file.
 */
`default_nettype none

module operand_gather (
    input  wire rv_decode_pkg::instr_u                  instr_i,
    input  wire [rv_decode_pkg::IMM_SEL_W-1:0]          imm_sel_i,
    input  wire                                         alu_rhs_imm_i,
    input  wire [rv_decode_pkg::XLEN-1:0]               rs1_data_i,
    input  wire [rv_decode_pkg::XLEN-1:0]               rs2_data_i,
    output rv_decode_pkg::operand_t                     operand_o
);

    import rv_decode_pkg::*;

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_shamt;
    logic [XLEN-1:0] imm;

    // ------------------------------
    // Immediate formats
    // ------------------------------
    assign imm_i = {{(XLEN-12){instr_i.i_view.imm12[11]}}, instr_i.i_view.imm12};

    assign imm_s = {{(XLEN-12){instr_i.r_view.funct7[6]}},
                    instr_i.r_view.funct7, instr_i.r_view.rd};

    assign imm_b = {{(XLEN-12){instr_i.r_view.funct7[6]}},
                    instr_i.r_view.rd[0], instr_i.r_view.funct7[5:0],
                    instr_i.r_view.rd[4:1], 1'b0};

    assign imm_u = {instr_i.r_view.funct7, instr_i.r_view.rs2, instr_i.r_view.rs1,
                    instr_i.r_view.funct3, 12'b0};

    // instr[19:12], instr[20], instr[30:21]
    assign imm_j = {{(XLEN-20){instr_i.r_view.funct7[6]}},
                    instr_i.r_view.rs1, instr_i.r_view.funct3,
                    instr_i.r_view.rs2[0], instr_i.r_view.funct7[5:0],
                    instr_i.r_view.rs2[4:1], 1'b0};

    assign imm_shamt = {{(XLEN-REG_ADDR_W){1'b0}}, instr_i.r_view.rs2};  // Zero extended

    always_comb begin
        case (imm_sel_i)
            IMM_SEL_I:     imm = imm_i;
            IMM_SEL_S:     imm = imm_s;
            IMM_SEL_B:     imm = imm_b;
            IMM_SEL_U:     imm = imm_u;
            IMM_SEL_J:     imm = imm_j;
            IMM_SEL_SHAMT: imm = imm_shamt;
            default:       imm = '0;  // IMM_SEL_NONE
        endcase
    end

    // ------------------------------
    // ALU operands
    // ------------------------------
    assign operand_o.rs1_data = rs1_data_i;
    assign operand_o.rs2_data = rs2_data_i;
    assign operand_o.imm      = imm;
    assign operand_o.alu_lhs  = rs1_data_i;
    assign operand_o.alu_rhs  = alu_rhs_imm_i ? imm : rs2_data_i;

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
/*
 * RV32I decode and operand gather stage
 * Connects PC tracking, instruction decode and operand gather
 * between fetch, the register file and execute.
 */
`default_nettype none

module decode_stage (
    input  wire                                       g_clk,
    input  wire                                       g_resetn,
    input  wire                                       instr_valid_i,
    input  wire [rv_decode_pkg::INSTR_W-1:0]          instr_i,
    input  wire                                       ferr_i,
    output logic                                      eat_o,
    input  wire                                       s2_ready_i,
    output logic                                      s2_valid_o,
    input  wire                                       cf_valid_i,
    input  wire                                       cf_ack_i,
    input  wire [rv_decode_pkg::XLEN-1:0]             cf_target_i,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0]      rs1_addr_o,
    input  wire [rv_decode_pkg::XLEN-1:0]             rs1_data_i,
    output logic [rv_decode_pkg::REG_ADDR_W-1:0]      rs2_addr_o,
    input  wire [rv_decode_pkg::XLEN-1:0]             rs2_data_i,
    output rv_decode_pkg::uop_t                       uop_o,
    output rv_decode_pkg::operand_t                   operand_o,
    output logic [rv_decode_pkg::XLEN-1:0]            pc_o,
    output logic [rv_decode_pkg::XLEN-1:0]            npc_o,
    output logic                                      trap_o
);

    import rv_decode_pkg::*;

    instr_u                 instr_w;      // Fetched word seen through its views
    logic [IMM_SEL_W-1:0]   imm_sel;
    logic                   alu_rhs_imm;

    assign instr_w    = instr_i;
    assign s2_valid_o = instr_valid_i;    // Single item, no buffering

    pc_tracker u_pc_tracker (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .s2_ready_i    (s2_ready_i),
        .cf_valid_i    (cf_valid_i),
        .cf_ack_i      (cf_ack_i),
        .cf_target_i   (cf_target_i),
        .eat_o         (eat_o),
        .pc_o          (pc_o),
        .npc_o         (npc_o)
    );

    instr_decode u_instr_decode (
        .instr_i       (instr_w),
        .ferr_i        (ferr_i),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .uop_o         (uop_o),
        .imm_sel_o     (imm_sel),
        .alu_rhs_imm_o (alu_rhs_imm),
        .trap_o        (trap_o)
    );

    operand_gather u_operand_gather (
        .instr_i       (instr_w),
        .imm_sel_i     (imm_sel),
        .alu_rhs_imm_i (alu_rhs_imm),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .operand_o     (operand_o)
    );

endmodule

`default_nettype wire

//--- sim/tb_decode_stage.sv
/*
 * Decode stage testbench
 * Applies a table of RV32I words with fetch and execute handshakes,
 * and checks the micro-op, operands, trap and PC progression.
 */
`default_nettype none

module tb_decode_stage;

    import rv_decode_pkg::*;

    typedef struct {
        logic [INSTR_W-1:0]    instr;
        logic                  ferr;
        logic                  ready;
        logic                  redir;    // Acknowledged redirect on this row
        logic [XLEN-1:0]       target;
        logic [REG_ADDR_W-1:0] rs1;      // Expected register reads
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic                  rhs_imm;  // ALU right operand is the immediate
        logic                  trap;
        uop_t                  uop;
    } row_t;

    logic                  g_clk;
    logic                  g_resetn;
    logic                  instr_valid_i;
    logic [INSTR_W-1:0]    instr_i;
    logic                  ferr_i;
    logic                  eat_o;
    logic                  s2_ready_i;
    logic                  s2_valid_o;
    logic                  cf_valid_i;
    logic                  cf_ack_i;
    logic [XLEN-1:0]       cf_target_i;
    logic [REG_ADDR_W-1:0] rs1_addr_o;
    logic [XLEN-1:0]       rs1_data_i;
    logic [REG_ADDR_W-1:0] rs2_addr_o;
    logic [XLEN-1:0]       rs2_data_i;
    uop_t                  uop_o;
    operand_t              operand_o;
    logic [XLEN-1:0]       pc_o;
    logic [XLEN-1:0]       npc_o;
    logic                  trap_o;

    logic [XLEN-1:0]       rf [32];      // Register file model
    row_t                  rows [$];
    logic [XLEN-1:0]       exp_pc;       // PC reference model
    int                    checks = 0;
    int                    errors = 0;
    int                    cycle_count = 0;
    int                    cycle_limit = 0;

    decode_stage dut_i (.*);

    assign rs1_data_i = rf[rs1_addr_o];  // Same-cycle read
    assign rs2_data_i = rf[rs2_addr_o];

    always #20 g_clk = ~g_clk;           // 40-unit period

    always @(posedge g_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the test did not complete within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [XLEN-1:0] xorshift32(input logic [XLEN-1:0] state);
        logic [XLEN-1:0] x;

        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_uop(input string name, input uop_t got, input uop_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_operand(input string name, input operand_t got, input operand_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [REG_ADDR_W-1:0] got,
                              input logic [REG_ADDR_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_row(input row_t r);
        operand_t exp_op;

        exp_op.rs1_data = rf[r.rs1];
        exp_op.rs2_data = rf[r.rs2];
        exp_op.imm      = r.imm;
        exp_op.alu_lhs  = rf[r.rs1];
        exp_op.alu_rhs  = r.rhs_imm ? r.imm : rf[r.rs2];
        check_addr("rs1_addr_o", rs1_addr_o, r.rs1);
        check_addr("rs2_addr_o", rs2_addr_o, r.rs2);
        check_uop("uop_o", uop_o, r.uop);
        check_operand("operand_o", operand_o, exp_op);
        check_bit("trap_o", trap_o, r.trap);
        check_bit("eat_o", eat_o, r.ready);      // Fetch is always valid here
        check_bit("s2_valid_o", s2_valid_o, 1'b1);
        check_word("pc_o", pc_o, exp_pc);
        check_word("npc_o", npc_o, exp_pc + 32'd4);
    endtask

    task automatic add_row(input logic [INSTR_W-1:0] word, input logic fe, input logic rdy,
                           input logic redir, input logic [XLEN-1:0] tgt,
                           input logic [REG_ADDR_W-1:0] a1, input logic [REG_ADDR_W-1:0] a2,
                           input logic [XLEN-1:0] imm, input logic rhs_imm, input logic trp,
                           input uop_t u);
        rows.push_back(row_t'{word, fe, rdy, redir, tgt, a1, a2, imm, rhs_imm, trp, u});
    endtask

    // ------------------------------
    // Stimulus table
    // ------------------------------
    task automatic build_table();
        // ALU, register and immediate forms
        add_row(32'h002081B3, 1'b0, 1'b1, 1'b0, '0, 5'd1, 5'd2, '0, 1'b0, 1'b0,
                uop_t'{alu_add: '1, wb_alu: '1, rd: 5'd3, default: '0});   // add x3,x1,x2
        add_row(32'h407302B3, 1'b0, 1'b0, 1'b0, '0, 5'd6, 5'd7, '0, 1'b0, 1'b0,
                uop_t'{alu_sub: '1, wb_alu: '1, rd: 5'd5, default: '0});   // Held by execute
        add_row(32'h407302B3, 1'b0, 1'b1, 1'b0, '0, 5'd6, 5'd7, '0, 1'b0, 1'b0,
                uop_t'{alu_sub: '1, wb_alu: '1, rd: 5'd5, default: '0});
        add_row(32'h40A4D433, 1'b0, 1'b1, 1'b0, '0, 5'd9, 5'd10, '0, 1'b0, 1'b0,
                uop_t'{alu_sra: '1, wb_alu: '1, rd: 5'd8, default: '0});
        add_row(32'h00D635B3, 1'b0, 1'b1, 1'b0, '0, 5'd12, 5'd13, '0, 1'b0, 1'b0,
                uop_t'{alu_sltu: '1, wb_alu: '1, rd: 5'd11, default: '0});
        add_row(32'hFFB10093, 1'b0, 1'b1, 1'b0, '0, 5'd2, 5'd0, 32'hFFFFFFFB, 1'b1, 1'b0,
                uop_t'{alu_add: '1, wb_alu: '1, rd: 5'd1, default: '0});   // addi -5
        add_row(32'h40D3D313, 1'b0, 1'b1, 1'b0, '0, 5'd7, 5'd0, 32'h0000000D, 1'b1, 1'b0,
                uop_t'{alu_sra: '1, wb_alu: '1, rd: 5'd6, default: '0});   // srai 13
        add_row(32'h01F51493, 1'b0, 1'b1, 1'b0, '0, 5'd10, 5'd0, 32'h0000001F, 1'b1, 1'b0,
                uop_t'{alu_sll: '1, wb_alu: '1, rd: 5'd9, default: '0});
        add_row(32'hABCDE637, 1'b0, 1'b1, 1'b0, '0, 5'd0, 5'd0, 32'hABCDE000, 1'b1, 1'b0,
                uop_t'{alu_or: '1, wb_alu: '1, rd: 5'd12, default: '0});   // LUI
        add_row(32'h80000697, 1'b0, 1'b1, 1'b0, '0, 5'd0, 5'd0, 32'h80000000, 1'b1, 1'b0,
                uop_t'{alu_add: '1, wb_alu: '1, rd: 5'd13, default: '0});  // AUIPC

        // Loads and stores
        add_row(32'hFFF78703, 1'b0, 1'b1, 1'b0, '0, 5'd15, 5'd0, 32'hFFFFFFFF, 1'b0, 1'b0,
                uop_t'{lsu_load: '1, lsu_byte: '1, lsu_sext: '1, wb_lsu: '1, rd: 5'd14,
                       default: '0});
        add_row(32'h7FE15083, 1'b0, 1'b1, 1'b0, '0, 5'd2, 5'd0, 32'h000007FE, 1'b0, 1'b0,
                uop_t'{lsu_load: '1, lsu_half: '1, wb_lsu: '1, rd: 5'd1, default: '0});
        add_row(32'hFE532E23, 1'b0, 1'b1, 1'b1, 32'h20000040, 5'd6, 5'd5, 32'hFFFFFFFC,
                1'b0, 1'b0, uop_t'{lsu_store: '1, lsu_word: '1, default: '0});
        add_row(32'h027402A3, 1'b0, 1'b1, 1'b0, '0, 5'd8, 5'd7, 32'h00000025, 1'b0, 1'b0,
                uop_t'{lsu_store: '1, lsu_byte: '1, default: '0});

        // Branches and jumps
        add_row(32'hFE208CE3, 1'b0, 1'b1, 1'b0, '0, 5'd1, 5'd2, 32'hFFFFFFF8, 1'b0, 1'b0,
                uop_t'{alu_sub: '1, cfu_beq: '1, default: '0});
        add_row(32'h0062C0E3, 1'b0, 1'b1, 1'b0, '0, 5'd5, 5'd6, 32'h00000800, 1'b0, 1'b0,
                uop_t'{alu_sub: '1, cfu_blt: '1, default: '0});            // imm[11] from bit 7
        add_row(32'hFFDFF0EF, 1'b0, 1'b0, 1'b1, 32'h00000800, 5'd0, 5'd0, 32'hFFFFFFFC,
                1'b0, 1'b0, uop_t'{cfu_jal: '1, wb_npc: '1, rd: 5'd1, default: '0});
        add_row(32'h344122EF, 1'b0, 1'b1, 1'b0, '0, 5'd0, 5'd0, 32'h00012344, 1'b0, 1'b0,
                uop_t'{cfu_jal: '1, wb_npc: '1, rd: 5'd5, default: '0});
        add_row(32'h00C08067, 1'b0, 1'b1, 1'b0, '0, 5'd1, 5'd0, 32'h0000000C, 1'b0, 1'b0,
                uop_t'{cfu_jalr: '1, wb_npc: '1, default: '0});

        // Traps
        add_row(32'h00000073, 1'b0, 1'b1, 1'b0, '0, 5'd0, 5'd0, '0, 1'b0, 1'b1,
                uop_t'{default: '0});                                     // ecall is unlisted
        add_row(32'h002081B3, 1'b1, 1'b1, 1'b0, '0, 5'd1, 5'd2, '0, 1'b0, 1'b1,
                uop_t'{alu_add: '1, wb_alu: '1, rd: 5'd3, default: '0});   // Fetch error
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [XLEN-1:0] state;
        logic [5:0]      a;

        g_clk         = 1'b0;
        g_resetn      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        ferr_i        = 1'b0;
        s2_ready_i    = 1'b0;
        cf_valid_i    = 1'b0;
        cf_ack_i      = 1'b0;
        cf_target_i   = '0;

        state = 32'd39614;
        rf[0] = '0;                          // x0 reads zero
        for (a = 6'd1; a < 6'd32; a = a + 6'd1) begin
            state      = xorshift32(state);
            rf[a[4:0]] = state;
        end

        build_table();
        cycle_limit = rows.size() * 4 + 20;

        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn    = 1'b1;
        s2_ready_i  = 1'b1;                  // Execute ready while fetch is idle
        cf_valid_i  = 1'b1;                  // Redirect requested but not acknowledged
        cf_target_i = 32'h3000_0000;
        exp_pc      = PC_RESET_ADDR;
        #10;
        check_word("pc_o", pc_o, exp_pc);
        check_bit("eat_o", eat_o, 1'b0);
        check_bit("s2_valid_o", s2_valid_o, 1'b0);
        repeat (2) @(negedge g_clk);
        check_word("pc_o", pc_o, exp_pc);     // Idle fetch leaves the PC alone
        cf_valid_i = 1'b0;
        cf_ack_i   = 1'b1;                   // Acknowledge with nothing requested
        @(negedge g_clk);
        check_word("pc_o", pc_o, exp_pc);

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge g_clk);
            instr_valid_i = 1'b1;
            instr_i       = rows[i].instr;
            ferr_i        = rows[i].ferr;
            s2_ready_i    = rows[i].ready;
            cf_valid_i    = rows[i].redir;
            cf_ack_i      = rows[i].redir;
            cf_target_i   = rows[i].target;
            #10;
            check_row(rows[i]);
            if (rows[i].redir) begin
                exp_pc = rows[i].target;     // Redirect beats consumption
            end else if (rows[i].ready) begin
                exp_pc = exp_pc + 32'd4;
            end
            @(posedge g_clk);
        end

        @(negedge g_clk);
        instr_valid_i = 1'b0;
        s2_ready_i    = 1'b1;                // Fetch idle with execute ready
        cf_valid_i    = 1'b0;
        cf_ack_i      = 1'b0;
        #10;
        check_word("pc_o", pc_o, exp_pc);
        check_bit("eat_o", eat_o, 1'b0);
        check_bit("s2_valid_o", s2_valid_o, 1'b0);
        @(negedge g_clk);
        check_word("pc_o", pc_o, exp_pc);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_decode.f
hdl/rv_decode_pkg.sv
hdl/pc_tracker.sv
hdl/instr_decode.sv
hdl/operand_gather.sv
hdl/decode_stage.sv
sim/tb_decode_stage.sv

//--- Makefile
# Verilator simulation of the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= rv_decode.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# Build, run, and fail unless the pass line is printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
